// File: all.f
+incdir+rtl
rtl/wam_field_pkg.sv
rtl/wam_game_pkg.sv
rtl/mole_if.sv
rtl/press_detect.sv
rtl/mole_spawner.sv
rtl/game_fsm.sv
rtl/whack_top.sv
verif/tb_whack.sv

// File: rtl/game_fsm.sv
`include "wam_cfg.svh"

// Game controller
// Runs idle, play and end screen, judges presses against the lit hole,
// keeps score and lives and drives the mole lights

module game_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  wam_field_pkg::hole_mask_t press,
    mole_if.game                      mif,
    output wam_field_pkg::hole_mask_t mole,
    output wam_game_pkg::score_t      score,
    output wam_game_pkg::lives_t      lives,
    output wam_game_pkg::game_state_e state
);
    import wam_field_pkg::*;
    import wam_game_pkg::*;

    score_t     level;       // Speed-up steps earned
    delay_t     window_len;  // Hammer window for the next mole
    delay_t     win_cnt;     // Cycles left for the lit mole, this one included
    delay_t     blink_cnt;   // End screen half period counter
    logic       blink_on;    // Mole 0 on the end screen
    hole_mask_t lit_mask;    // One-hot of the spawner's hole
    logic       lit;         // Mole shown and not yet judged
    logic       hit;
    logic       miss;

    ////////////////////////////////////////////////////////////////////////
    // Level and hammer window
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        // Score must be strictly past 10, 20, ... for each step
        if (score == '0) begin
            level = '0;
        end else begin
            level = (score - score_t'(1)) / score_t'(`WAM_LEVEL_STEP);
        end
        if (level > score_t'(`WAM_LEVEL_MAX)) begin
            level = score_t'(`WAM_LEVEL_MAX);  // Shortest window reached
        end
    end

    assign window_len = delay_t'(`WAM_WINDOW) - delay_t'(level) * delay_t'(`WAM_SPEEDUP);

    ////////////////////////////////////////////////////////////////////////
    // Judging
    ////////////////////////////////////////////////////////////////////////
    assign lit      = (state == PLAY) && mif.up && !mif.clear;
    assign lit_mask = hole_mask_t'(1) << mif.hole;

    // Only the lit button, nothing else in the same cycle
    assign hit  = lit && (press == lit_mask);
    // Any unlit button, or last cycle of the window gone by
    assign miss = lit && ((|(press & ~lit_mask)) || (win_cnt == delay_t'(1)));

    ////////////////////////////////////////////////////////////////////////
    // State, score, lives, mole hand-shake
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            score     <= '0;
            lives     <= lives_t'(`WAM_LIVES);
            mif.arm   <= 1'b0;
            mif.clear <= 1'b1;  // Spawner held dark
            win_cnt   <= '0;
            blink_cnt <= '0;
            blink_on  <= 1'b0;
        end else begin
            mif.arm <= 1'b0;  // Single cycle unless set below
            case (state)
                IDLE: begin
                    mif.clear <= 1'b1;
                    if (|press) begin  // Any button starts a game
                        state     <= PLAY;
                        score     <= '0;
                        lives     <= lives_t'(`WAM_LIVES);
                        mif.clear <= 1'b0;
                        mif.arm   <= 1'b1;  // First mole
                    end
                end

                PLAY: begin
                    if (mif.clear) begin
                        // Mole dismissed last cycle, request the next one
                        mif.clear <= 1'b0;
                        mif.arm   <= 1'b1;
                    end else if (hit) begin
                        score     <= score + 1'b1;
                        mif.clear <= 1'b1;
                    end else if (miss) begin
                        lives     <= lives - 1'b1;
                        mif.clear <= 1'b1;
                        if (lives == lives_t'(1)) begin
                            state     <= OVER;  // Last life gone
                            blink_cnt <= '0;
                            blink_on  <= 1'b0;
                        end
                    end
                    // Window reloads while dark, counts down while lit
                    if (lit) begin
                        win_cnt <= win_cnt - 1'b1;
                    end else begin
                        win_cnt <= window_len;
                    end
                end

                OVER: begin
                    mif.clear <= 1'b1;
                    if (blink_cnt == delay_t'(`WAM_BLINK - 1)) begin
                        blink_cnt <= '0;
                        blink_on  <= ~blink_on;
                    end else begin
                        blink_cnt <= blink_cnt + 1'b1;
                    end
                    if (press[0]) begin  // Only button 0 leaves the end screen
                        state <= IDLE;
                        lives <= lives_t'(`WAM_LIVES);
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Mole lights
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        mole = '0;
        if (state == OVER) begin
            mole[0] = blink_on;  // End screen blink
        end else if (lit) begin
            mole = lit_mask;
        end
    end

endmodule

// File: rtl/mole_if.sv
// Mole request and answer between spawner and game controller
interface mole_if;
    import wam_field_pkg::*;

    logic  arm;    // Game asks for a new mole, one cycle
    logic  clear;  // Game forces spawner idle and dark
    logic  up;     // Mole is out
    hole_t hole;   // Which hole, valid with up

    // Spawner side
    modport spawner (
        input  arm,
        input  clear,
        output up,
        output hole
    );

    // Game controller side
    modport game (
        output arm,
        output clear,
        input  up,
        input  hole
    );

endinterface

// File: rtl/mole_spawner.sv
`include "wam_cfg.svh"

// Picks a pseudo-random hole and delay on each arm request
// One down-counter runs from arm to the moment the mole shows

module mole_spawner (
    input logic     clk,
    input logic     reset,
    mole_if.spawner mif
);
    import wam_field_pkg::*;

    logic [15:0] lfsr;         // Free running random source
    logic        lfsr_fb;      // Feedback bit
    delay_t      spawn_delay;  // Delay picked for the next mole
    delay_t      cnt;          // Cycles until the mole shows, zero when idle
    hole_t       hole_r;       // Hole latched at arm
    logic        up_r;         // Mole out

    ////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////
    // Taps 16, 14, 13, 11 give the maximal length sequence
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `WAM_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};  // Steps every cycle, also between moles
        end
    end

    // Low bits give the spread, top bits give the hole
    assign spawn_delay = delay_t'(`WAM_SPAWN_MIN)
                       + delay_t'(lfsr % 16'(`WAM_SPAWN_SPAN));

    ////////////////////////////////////////////////////////////////////////
    // Spawn timer
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            up_r <= 1'b0;
        end else if (mif.clear) begin
            // Dismissed or game not running
            cnt  <= '0;
            up_r <= 1'b0;
        end else if (mif.arm && !up_r) begin
            // One less, up is registered one cycle after cnt hits 1
            cnt <= spawn_delay - 1'b1;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == delay_t'(1)) begin
                up_r <= 1'b1;  // Timer expired, mole shows
            end
        end
    end

    // Hole choice, only meaningful once up is high
    always_ff @(posedge clk) begin
        if (mif.arm && !up_r && !mif.clear) begin
            hole_r <= lfsr[15 -: $bits(hole_t)];
        end
    end

    assign mif.up   = up_r;
    assign mif.hole = hole_r;

endmodule

// File: rtl/press_detect.sv
// Rising edge detect on the four hole buttons
// Buttons are expected debounced and synchronous to clk

module press_detect (
    input  logic                      clk,
    input  logic                      reset,
    input  wam_field_pkg::hole_mask_t button,
    output wam_field_pkg::hole_mask_t press
);
    import wam_field_pkg::*;

    hole_mask_t button_prev;  // Button sample from the last cycle

    ////////////////////////////////////////////////////////////////////////
    // Previous sample
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // All ones so a button held through reset is no press
            button_prev <= '1;
        end else begin
            button_prev <= button;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Press pulses
    ////////////////////////////////////////////////////////////////////////
    // High now and low a cycle ago, so one cycle per push
    assign press = button & ~button_prev;

endmodule

// File: rtl/wam_cfg.svh
`ifndef WAM_CFG_SVH
`define WAM_CFG_SVH

////////////////////////////////////////////////////////////////////////
// Field size and counter width
////////////////////////////////////////////////////////////////////////
`define WAM_HOLES       4         // Holes and buttons
`define WAM_DELAY_W     16        // Spawn, window and blink counters

////////////////////////////////////////////////////////////////////////
// Game timing in clock cycles
////////////////////////////////////////////////////////////////////////
`define WAM_SPAWN_MIN   8         // Shortest wait before a mole shows
`define WAM_SPAWN_SPAN  8         // Random spread on top of the minimum
`define WAM_WINDOW      40        // Hammer window at level 0
`define WAM_SPEEDUP     3         // Window cut per level
`define WAM_LEVEL_MAX   9         // Speed-up stops here
`define WAM_LEVEL_STEP  10        // Score points per level
`define WAM_LIVES       3         // Lives at game start
`define WAM_BLINK       16        // End screen half period
`define WAM_LFSR_SEED   16'hace1  // Must not be zero

`endif

// File: rtl/wam_field_pkg.sv
`include "wam_cfg.svh"

// Playing field types shared by spawner, game and top
package wam_field_pkg;

    // Hole number, enough bits for every hole
    typedef logic [$clog2(`WAM_HOLES)-1:0] hole_t;

    // One bit per hole, bit 0 is hole 0
    typedef logic [`WAM_HOLES-1:0] hole_mask_t;

    // Down-counter value for spawn delay, hammer window and blink
    typedef logic [`WAM_DELAY_W-1:0] delay_t;

endpackage

// File: rtl/wam_game_pkg.sv
// Game progress types

package wam_game_pkg;

    // Top level game sequence
    typedef enum logic [1:0] {
        IDLE = 2'd0,   // Waiting for any press
        PLAY = 2'd1,   // Moles popping up
        OVER = 2'd2    // End screen, blinking mole 0
    } game_state_e;

    // Hits so far, wraps past 127
    typedef logic [6:0] score_t;

    // Lives left, three at most
    typedef logic [1:0] lives_t;

endpackage

// File: rtl/whack_top.sv
// Whack-a-mole core top level
// Button edges feed the game controller, the spawner supplies the moles

module whack_top (
    input  logic                      clk,
    input  logic                      reset,
    input  wam_field_pkg::hole_mask_t button,  // Debounced, synchronous
    output wam_field_pkg::hole_mask_t mole,    // One lamp per hole
    output wam_game_pkg::score_t      score,
    output wam_game_pkg::lives_t      lives,
    output wam_game_pkg::game_state_e state
);
    import wam_field_pkg::*;

    hole_mask_t press;  // One-cycle press pulses

    mole_if mif ();     // Spawner to game hand-over

    ////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////
    press_detect u_press_detect (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .press  (press)
    );

    mole_spawner u_mole_spawner (
        .clk   (clk),
        .reset (reset),
        .mif   (mif.spawner)
    );

    game_fsm u_game_fsm (
        .clk   (clk),
        .reset (reset),
        .press (press),
        .mif   (mif.game),
        .mole  (mole),
        .score (score),
        .lives (lives),
        .state (state)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the whack-a-mole testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_whack -f all.f -o sim_whack
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_whack 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

# Result decided by the message the testbench prints
if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verif/tb_whack.sv
`include "wam_cfg.svh"

module tb_whack;
    timeunit 1ns;
    timeprecision 1ps;

    import wam_field_pkg::*;
    import wam_game_pkg::*;

    localparam int PERIOD    = 40;
    localparam int ROUNDS    = 16;  // Mole rounds played plus one spare
    localparam int ROUND_MAX = `WAM_SPAWN_MIN + `WAM_SPAWN_SPAN + `WAM_WINDOW + 10;
    localparam int LIMIT     = ROUNDS * ROUND_MAX + 4 * `WAM_BLINK + 60;

    logic        clk;
    logic        reset;
    hole_mask_t  button;
    hole_mask_t  mole;
    score_t      score;
    lives_t      lives;
    game_state_e state;

    hole_mask_t  button_q;    // Buttons at the last edge
    hole_mask_t  edge_now;    // Buttons that went high this cycle
    score_t      ref_score;
    lives_t      ref_lives;
    int          light_cnt;   // Cycles the current mole has been lit
    int          over_cnt;    // Cycles on the end screen
    int          exp_win;     // Window for the current score
    logic        lit_now;
    logic        hit_now;
    logic        miss_now;
    int unsigned rnd_state;
    int          err_cnt;
    int          fail_tests;

    whack_top DUT (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .mole   (mole),
        .score  (score),
        .lives  (lives),
        .state  (state)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Watchdog covering the longest round times the round count plus the end screen
    initial begin
        #(LIMIT * PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", LIMIT);
        $display("Simulation failed");
        $finish;
    end

    function automatic int unsigned next_random();
        rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
        return rnd_state >> 16;
    endfunction

    // One step per multiple of ten strictly passed
    function automatic int window_for(input score_t s);
        int steps;
        steps = 0;
        for (int k = 1; k <= `WAM_LEVEL_MAX; k++) begin
            if (int'(s) > k * `WAM_LEVEL_STEP) steps = k;
        end
        return `WAM_WINDOW - steps * `WAM_SPEEDUP;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Reference model from observed events
    ////////////////////////////////////////////////////////////////////
    assign edge_now = button & ~button_q;
    assign lit_now  = (state == PLAY) && (mole != '0);
    assign exp_win  = window_for(ref_score);
    assign hit_now  = lit_now && (edge_now == mole);
    assign miss_now = lit_now && ((|(edge_now & ~mole))
                      || (edge_now == '0 && light_cnt + 1 == exp_win));  // Window used up

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            button_q  <= '1;  // Held through reset counts as no press
            ref_score <= '0;
            ref_lives <= lives_t'(`WAM_LIVES);
            light_cnt <= 0;
            over_cnt  <= 0;
        end else begin
            button_q  <= button;
            light_cnt <= lit_now ? light_cnt + 1 : 0;
            over_cnt  <= (state == OVER) ? over_cnt + 1 : 0;
            if (state == IDLE && edge_now != '0) begin
                ref_score <= '0;
                ref_lives <= lives_t'(`WAM_LIVES);
            end else if (hit_now) begin
                ref_score <= ref_score + score_t'(1);
            end else if (miss_now) begin
                ref_lives <= ref_lives - lives_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////
    a_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(mole))
        else begin
            $display("** Error: mole = 0x%h has more than one bit set", $sampled(mole));
            err_cnt++;
        end
    a_score: assert property (@(posedge clk) disable iff (reset)
        (state != IDLE) |-> (score == ref_score))
        else begin
            $display("** Error: score = 0x%h, expected 0x%h",
                     $sampled(score), $sampled(ref_score));
            err_cnt++;
        end
    a_lives: assert property (@(posedge clk) disable iff (reset)
        (state != IDLE) |-> (lives == ref_lives))
        else begin
            $display("** Error: lives = 0x%h, expected 0x%h",
                     $sampled(lives), $sampled(ref_lives));
            err_cnt++;
        end
    a_start: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && edge_now != '0) |=> (state == PLAY))
        else begin
            $display("** Error: state = 0x%h, expected 0x%h after start", $sampled(state), PLAY);
            err_cnt++;
        end
    a_hit_dark: assert property (@(posedge clk) disable iff (reset) hit_now |=> (mole == '0))
        else begin
            $display("** Error: mole = 0x%h, expected 0x0 after hit", $sampled(mole));
            err_cnt++;
        end
    a_miss_dark: assert property (@(posedge clk) disable iff (reset) miss_now |=> (mole == '0))
        else begin
            $display("** Error: mole = 0x%h, expected 0x0 after miss", $sampled(mole));
            err_cnt++;
        end
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (lit_now && edge_now == '0 && light_cnt + 1 < exp_win) |=> (mole == $past(mole)))
        else begin
            $display("** Error: mole = 0x%h, expected lit for 0x%h cycles, left after 0x%h",
                     $sampled(mole), $sampled(exp_win), $sampled(light_cnt));
            err_cnt++;
        end
    a_over: assert property (@(posedge clk) disable iff (reset)
        (miss_now && ref_lives == lives_t'(1)) |=> (state == OVER))
        else begin
            $display("** Error: state = 0x%h, expected 0x%h", $sampled(state), OVER);
            err_cnt++;
        end
    a_blink: assert property (@(posedge clk) disable iff (reset)
        (state == OVER) |-> (mole == hole_mask_t'((over_cnt / `WAM_BLINK) % 2)))
        else begin
            $display("** Error: mole = 0x%h, expected 0x%h on end screen", $sampled(mole),
                     hole_mask_t'(($sampled(over_cnt) / `WAM_BLINK) % 2));
            err_cnt++;
        end
    a_stay: assert property (@(posedge clk) disable iff (reset)
        (state == OVER && !edge_now[0]) |=> (state == OVER))
        else begin
            $display("** Error: state = 0x%h, expected 0x%h", $sampled(state), OVER);
            err_cnt++;
        end
    a_exit: assert property (@(posedge clk) disable iff (reset)
        (state == OVER && edge_now[0]) |=> (state == IDLE))
        else begin
            $display("** Error: state = 0x%h, expected 0x%h", $sampled(state), IDLE);
            err_cnt++;
        end

    ////////////////////////////////////////////////////////////////////
    // Stimulus tasks that start and end on a falling edge
    ////////////////////////////////////////////////////////////////////
    task automatic tap(input hole_mask_t b);
        button = b;      // Seen on the next rising edge
        @(negedge clk);
        button = '0;
    endtask

    task automatic wait_state(input game_state_e s, input int limit);
        int n;
        n = 0;
        while (state != s && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (state != s) begin
            $display("Timeout: state did not reach %s within %0d cycles", s.name(), limit);
            err_cnt++;
        end
    endtask

    // Waits for a mole, then hits it (0), presses a wrong hole (1) or lets it go (2)
    task automatic play_round(input int action);
        hole_mask_t seen;
        hole_mask_t wrong;
        int         n;
        n = 0;
        while (!lit_now && n < ROUND_MAX) begin
            @(negedge clk);
            n++;
        end
        seen = lit_now ? mole : '0;
        if (seen == '0) begin
            $display("Timeout: no mole lit within %0d cycles", ROUND_MAX);
            err_cnt++;
        end else begin
            repeat (next_random() % 4) @(negedge clk);  // Reaction time
            wrong = seen;
            repeat (next_random() % 3 + 1) wrong = {wrong[2:0], wrong[3]};
            if (action == 0) tap(seen);
            else if (action == 1) tap(wrong);
            n = 0;
            while (lit_now && n < `WAM_WINDOW + 2) begin
                @(negedge clk);
                n++;
            end
            if (lit_now) begin
                $display("Timeout: mole still lit after the hammer window");
                err_cnt++;
            end
        end
    endtask

    task automatic finish_test(input int num, input string name, input int mark);
        int errs;
        @(negedge clk);  // Let the last implication settle
        errs = err_cnt - mark;
        if (errs != 0) fail_tests++;
        $display("Test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        int mark;
        button     = '0;
        reset      = 1'b1;
        err_cnt    = 0;
        fail_tests = 0;
        rnd_state  = 79;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        mark = err_cnt;
        @(negedge clk);
        assert (mole == '0 && score == '0 && lives == lives_t'(`WAM_LIVES) && state == IDLE)
            else begin
                $display("** Error: mole = 0x%h score = 0x%h lives = 0x%h state = 0x%h, %s",
                         mole, score, lives, state, "expected 0x0 0x00 0x3 0x0 after reset");
                err_cnt++;
            end
        finish_test(1, "reset state", mark);

        mark = err_cnt;
        tap(hole_mask_t'(4));
        wait_state(PLAY, 4);
        finish_test(2, "game start", mark);

        mark = err_cnt;
        repeat (12) play_round(0);  // Score past 10 for a shorter window
        finish_test(3, "correct hits", mark);

        mark = err_cnt;
        play_round(1);
        play_round(2);              // Expiry at level 1
        finish_test(4, "wrong press and expiry", mark);

        mark = err_cnt;
        play_round(int'(next_random() % 2) + 1);  // Last life
        wait_state(OVER, 4);
        repeat (3 * `WAM_BLINK) @(negedge clk);
        tap(hole_mask_t'(2));       // Not an exit button
        repeat (4) @(negedge clk);
        tap(hole_mask_t'(1));
        wait_state(IDLE, 4);
        finish_test(5, "end screen", mark);

        $display("Tests: 5 run, %0d failed, %0d errors", fail_tests, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
